//--- dv/btConnectionTb.sv
/*
	Testbench for the HC-05 serial bridge top level.
	Reset values, random transmit bytes decoded by a line monitor,
	random receive frames with interleaved framing errors checked
	against a model of the message store, clear, break and
	module state latency checks.
*/
`timescale 1ns/10ps

module btConnectionTb import btLinkPkg::*, hostEpPkg::*; ();

	localparam int WAIT_LIMIT = 4 * BIT_CLOCKS;

	logic clock;
	logic reset;
	logic btState;
	logic fpgaRxd;
	epWord_t ep01WireIn;
	epWord_t ep02WireIn;
	logic btBreak;
	logic fpgaTxd;
	epOutBank_t wireOuts;

	serialByte_t modelStore [STORE_BYTES]; // Index 0 is the newest byte.
	serialByte_t modelLast;
	byteCount_t modelCount;
	serialByte_t modelErrors;
	int valueErrors;
	int otherErrors;
	int unsigned seed;

	clockGen clockGenInst (.clock(clock));

	btConnection btConnection_inst (
		.clock(clock),
		.reset(reset),
		.btState(btState),
		.fpgaRxd(fpgaRxd),
		.ep01WireIn(ep01WireIn),
		.ep02WireIn(ep02WireIn),
		.btBreak(btBreak),
		.fpgaTxd(fpgaTxd),
		.wireOuts(wireOuts)
	);

	task automatic compareWord(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
			valueErrors++;
		end
	endtask

	task automatic clearModel();
		foreach (modelStore[i])
			modelStore[i] = '0;
		modelLast = '0;
		modelCount = '0;
		modelErrors = '0;
	endtask

	task automatic modelReceive(input serialByte_t data);
		for (int i = STORE_BYTES - 1; i > 0; i--)
			modelStore[i] = modelStore[i-1];
		modelStore[0] = data;
		modelLast = data;
		modelCount = modelCount + 1'b1;
	endtask

	// Busy is expected low while the transmitter is idle.
	function automatic epOutBank_t expectedBank();
		epOutBank_t bank;
		bank = '0;
		bank.status = {modelErrors, 8'h00};
		bank.status[0] = btState;
		bank.lastByte = {8'h00, modelLast};
		bank.store0 = {modelStore[1], modelStore[0]};
		bank.store1 = {modelStore[3], modelStore[2]};
		bank.store2 = {modelStore[5], modelStore[4]};
		bank.store3 = {modelStore[7], modelStore[6]};
		bank.store4 = {modelStore[9], modelStore[8]};
		bank.store5 = {modelStore[11], modelStore[10]};
		bank.store6 = {modelStore[13], modelStore[12]};
		bank.store7 = {modelStore[15], modelStore[14]};
		bank.rxCount = modelCount;
		return bank;
	endfunction

	task automatic checkBank(input epOutBank_t exp);
		compareWord("status", wireOuts.status, exp.status);
		compareWord("lastByte", wireOuts.lastByte, exp.lastByte);
		compareWord("store0", wireOuts.store0, exp.store0);
		compareWord("store1", wireOuts.store1, exp.store1);
		compareWord("store2", wireOuts.store2, exp.store2);
		compareWord("store3", wireOuts.store3, exp.store3);
		compareWord("store4", wireOuts.store4, exp.store4);
		compareWord("store5", wireOuts.store5, exp.store5);
		compareWord("store6", wireOuts.store6, exp.store6);
		compareWord("store7", wireOuts.store7, exp.store7);
		compareWord("rxCount", wireOuts.rxCount, exp.rxCount);
	endtask

	// Drives one 8N1 frame LSB first with a selectable stop level.
	task automatic driveRxFrame(input serialByte_t data, input logic stopLevel);
		@(negedge clock);
		fpgaRxd = 1'b0;
		repeat (BIT_CLOCKS) @(negedge clock);
		for (int i = 0; i < DATA_BITS; i++) begin
			fpgaRxd = data[i];
			repeat (BIT_CLOCKS) @(negedge clock);
		end
		fpgaRxd = stopLevel;
		repeat (BIT_CLOCKS) @(negedge clock);
		fpgaRxd = 1'b1;
		repeat (2 * BIT_CLOCKS) @(negedge clock); // Idle gap.
	endtask

	task automatic waitForBank(input epOutBank_t exp);
		int cycles;
		cycles = 0;
		while (wireOuts !== exp && cycles < WAIT_LIMIT) begin
			@(negedge clock);
			cycles++;
		end
		assert (wireOuts === exp) else begin
			$display("Timeout while waiting for the wire-out words after a received frame");
			otherErrors++;
		end
		checkBank(exp);
	endtask

	// Samples each bit of the frame on fpgaTxd in its middle.
	task automatic monitorTxFrame(input serialByte_t exp);
		int cycles;
		serialByte_t got;
		cycles = 0;
		got = '0;
		while (fpgaTxd !== 1'b0 && cycles < WAIT_LIMIT) begin
			@(negedge clock);
			cycles++;
		end
		assert (fpgaTxd === 1'b0) else begin
			$display("Timeout while waiting for a start bit on fpgaTxd");
			otherErrors++;
		end
		if (fpgaTxd === 1'b0) begin
			compareWord("start latency", cycles, 2);
			repeat (BIT_CLOCKS / 2 - 1) @(negedge clock);
			compareWord("fpgaTxd start bit", fpgaTxd, 1'b0);
			compareWord("status[1]", wireOuts.status[1], 1'b1);
			for (int i = 0; i < DATA_BITS; i++) begin
				repeat (BIT_CLOCKS) @(negedge clock);
				got[i] = fpgaTxd;
				compareWord("status[1]", wireOuts.status[1], 1'b1);
			end
			compareWord("fpgaTxd data", got, exp);
			repeat (BIT_CLOCKS) @(negedge clock);
			compareWord("fpgaTxd stop bit", fpgaTxd, 1'b1);
			compareWord("status[1]", wireOuts.status[1], 1'b1);
		end
	endtask

	task automatic transmitByte();
		serialByte_t expected;
		int cycles;
		@(negedge clock);
		ep01WireIn = epWord_t'($urandom); // Upper byte must be ignored.
		expected = ep01WireIn[7:0];
		ep02WireIn[0] = 1'b1;
		fork
			monitorTxFrame(expected);
			begin
				repeat (20) @(negedge clock);
				ep02WireIn[0] = 1'b0;
				repeat (4) @(negedge clock);
				ep02WireIn[0] = 1'b1; // Second edge while busy.
			end
		join
		cycles = 0;
		while (wireOuts.status[1] !== 1'b0 && cycles < WAIT_LIMIT) begin
			@(negedge clock);
			cycles++;
		end
		assert (wireOuts.status[1] === 1'b0) else begin
			$display("Timeout while waiting for the transmitter to become idle");
			otherErrors++;
		end
		repeat (3 * BIT_CLOCKS) begin
			@(negedge clock);
			compareWord("fpgaTxd idle", fpgaTxd, 1'b1);
		end
		ep02WireIn[0] = 1'b0;
		repeat (2) @(negedge clock);
	endtask

	initial begin
		int goodFrames;
		logic level;
		logic prevLevel;
		serialByte_t data;
		seed = 32'hca3e8bc4;
		void'($urandom(seed));
		valueErrors = 0;
		otherErrors = 0;
		reset = 1'b1;
		btState = 1'b0;
		fpgaRxd = 1'b1;
		ep01WireIn = '0;
		ep02WireIn = '0;
		clearModel();
		repeat (8) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);
		compareWord("fpgaTxd", fpgaTxd, 1'b1);
		compareWord("btBreak", btBreak, 1'b0);
		checkBank('0);

		for (int n = 0; n < 20; n++)
			transmitByte();

		// Bad stop bits interleaved with good frames.
		goodFrames = 0;
		while (goodFrames < 40) begin
			data = serialByte_t'($urandom);
			if ($urandom % 4 == 0) begin
				driveRxFrame(data, 1'b0);
				modelErrors = modelErrors + 1'b1;
			end else begin
				driveRxFrame(data, 1'b1);
				modelReceive(data);
				goodFrames++;
			end
			waitForBank(expectedBank());
		end

		@(negedge clock);
		ep02WireIn[2] = 1'b1;
		clearModel();
		repeat (2) @(negedge clock);
		checkBank(expectedBank());
		ep02WireIn[2] = 1'b0;

		for (int n = 0; n < 10; n++) begin
			@(negedge clock);
			level = $urandom % 2;
			ep02WireIn[1] = level;
			@(negedge clock);
			compareWord("btBreak", btBreak, level);
		end

		for (int n = 0; n < 10; n++) begin
			prevLevel = btState;
			level = $urandom % 2;
			@(negedge clock);
			btState = level;
			@(negedge clock);
			compareWord("status[0] after 1 cycle", wireOuts.status[0], prevLevel);
			@(negedge clock);
			compareWord("status[0]", wireOuts.status[0], level);
		end

		$display("Error counts: %0d wrong values, %0d other failures", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

//--- dv/clockGen.sv
/*
	Testbench clock source.
	Free-running 10 ns clock starting low.
*/
`timescale 1ns/10ps

module clockGen (
	output logic clock
);

	localparam time HALF_PERIOD = 5ns;

	initial clock = 1'b0;

	always #(HALF_PERIOD) clock = ~clock; // 100 MHz.

endmodule

//--- filelist.f
logic/btLinkPkg.sv
logic/hostEpPkg.sv
logic/uartTransmitter.sv
logic/uartReceiver.sv
logic/rxMessageStore.sv
logic/btConnection.sv
dv/clockGen.sv
dv/btConnectionTb.sv

//--- logic/btConnection.sv
/*
	Host-to-Bluetooth serial bridge top level.
	Decodes the host control word, runs the transmitter, receiver
	and message store, synchronizes the module state pin and
	packs the wire-out bank.
*/
`timescale 1ns/10ps

module btConnection import btLinkPkg::*, hostEpPkg::*; (
	input logic clock,
	input logic reset,
	input logic btState,
	input logic fpgaRxd,
	input epWord_t ep01WireIn,
	input epWord_t ep02WireIn,
	output logic btBreak,
	output logic fpgaTxd,
	output epOutBank_t wireOuts
);

	hostControl_t hostCtrl;
	logic sendPrev;
	logic clearPrev;
	logic [1:0] stateSync;
	logic txBusy;
	serialByte_t rxByte;
	logic rxValid;
	logic frameError;
	serialByte_t lastByte;
	storeBytes_t storeBytes;
	byteCount_t rxCount;
	serialByte_t errorCount;

	always_ff @(posedge clock) begin
		if (reset) begin
			hostCtrl <= '0;
			sendPrev <= 1'b0;
			clearPrev <= 1'b0;
			stateSync <= 2'b00;
		end else begin
			hostCtrl.sendLevel <= ep02WireIn[CTRL_SEND_BIT];
			hostCtrl.breakLink <= ep02WireIn[CTRL_BREAK_BIT];
			hostCtrl.clearLevel <= ep02WireIn[CTRL_CLEAR_BIT];
			sendPrev <= hostCtrl.sendLevel;
			clearPrev <= hostCtrl.clearLevel;
			stateSync <= {stateSync[0], btState}; // Asynchronous pin.
		end
	end

	wire sendPulse = hostCtrl.sendLevel && !sendPrev;
	wire clearPulse = hostCtrl.clearLevel && !clearPrev;

	assign btBreak = hostCtrl.breakLink;

	uartTransmitter txInst (
		.clock(clock),
		.reset(reset),
		.start(sendPulse),
		.txData(ep01WireIn[7:0]),
		.txd(fpgaTxd),
		.busy(txBusy)
	);

	uartReceiver rxInst (
		.clock(clock),
		.reset(reset),
		.rxd(fpgaRxd),
		.rxByte(rxByte),
		.rxValid(rxValid),
		.frameError(frameError)
	);

	rxMessageStore storeInst (
		.clock(clock),
		.reset(reset),
		.clear(clearPulse),
		.rxByte(rxByte),
		.rxValid(rxValid),
		.frameError(frameError),
		.lastByte(lastByte),
		.storeBytes(storeBytes),
		.rxCount(rxCount),
		.errorCount(errorCount)
	);

	always_comb begin
		wireOuts.status = {errorCount, 8'h00}; // Errors in the high byte.
		wireOuts.status[STATUS_STATE_BIT] = stateSync[1];
		wireOuts.status[STATUS_BUSY_BIT] = txBusy;
		wireOuts.lastByte = {8'h00, lastByte};
		wireOuts.store0 = storeBytes[0*16 +: 16]; // Newest byte is the low byte.
		wireOuts.store1 = storeBytes[1*16 +: 16];
		wireOuts.store2 = storeBytes[2*16 +: 16];
		wireOuts.store3 = storeBytes[3*16 +: 16];
		wireOuts.store4 = storeBytes[4*16 +: 16];
		wireOuts.store5 = storeBytes[5*16 +: 16];
		wireOuts.store6 = storeBytes[6*16 +: 16];
		wireOuts.store7 = storeBytes[7*16 +: 16];
		wireOuts.rxCount = rxCount;
	end

endmodule

//--- logic/btLinkPkg.sv
/*
	Serial link definitions for the HC-05 bridge.
	Bit period, byte and counter types, the received-message store
	type and the transmitter and receiver state encodings.
*/
package btLinkPkg;

	localparam int BIT_CLOCKS = 16; // Clocks per serial bit.
	localparam int DATA_BITS = 8;
	localparam int STORE_BYTES = 16; // Depth of the message store.

	typedef logic [DATA_BITS-1:0] serialByte_t;

	// Counts clocks within one bit.
	typedef logic [$clog2(BIT_CLOCKS)-1:0] bitTimer_t;

	// Index of the data bit in flight.
	typedef logic [$clog2(DATA_BITS)-1:0] bitIndex_t;

	typedef logic [15:0] byteCount_t; // Wraps.

	// Newest byte in bits 7:0.
	typedef logic [STORE_BYTES*DATA_BITS-1:0] storeBytes_t;

	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} rxState_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} txState_t;

endpackage

//--- logic/hostEpPkg.sv
/*
	Host endpoint definitions.
	Endpoint word type, wire-in addresses, the decoded control
	word and the bank of eleven wire-out words.
*/
package hostEpPkg;

	typedef logic [15:0] epWord_t;

	// Wire-in addresses as seen by the host software.
	localparam logic [7:0] EP_TX_BYTE = 8'h01; // Byte to send.
	localparam logic [7:0] EP_CONTROL = 8'h02; // Control levels.

	// Bit positions within the control word.
	localparam int CTRL_SEND_BIT = 0;
	localparam int CTRL_BREAK_BIT = 1;
	localparam int CTRL_CLEAR_BIT = 2;

	// Bit positions within the status word.
	localparam int STATUS_STATE_BIT = 0;
	localparam int STATUS_BUSY_BIT = 1;

	typedef struct packed {
		logic sendLevel; // Rising edge sends ep01 low byte.
		logic breakLink; // Drives the module enable pin.
		logic clearLevel; // Rising edge empties the store.
	} hostControl_t;

	// Field order follows ep20 to ep30.
	typedef struct packed {
		epWord_t status;
		epWord_t lastByte;
		epWord_t store0;
		epWord_t store1;
		epWord_t store2;
		epWord_t store3;
		epWord_t store4;
		epWord_t store5;
		epWord_t store6;
		epWord_t store7;
		epWord_t rxCount;
	} epOutBank_t;

endpackage

//--- logic/rxMessageStore.sv
/*
	Received-message store.
	Sixteen-byte shift store with the newest byte lowest, last
	byte register, wrapping byte count and framing error count.
*/
`timescale 1ns/10ps

module rxMessageStore import btLinkPkg::*; (
	input logic clock,
	input logic reset,
	input logic clear,
	input serialByte_t rxByte,
	input logic rxValid,
	input logic frameError,
	output serialByte_t lastByte,
	output storeBytes_t storeBytes,
	output byteCount_t rxCount,
	output serialByte_t errorCount
);

	always_ff @(posedge clock) begin
		if (reset || clear) begin
			storeBytes <= '0;
			lastByte <= '0;
			rxCount <= '0;
			errorCount <= '0;
		end else begin
			if (rxValid) begin
				// Oldest byte falls off the top.
				storeBytes <= {storeBytes[$bits(storeBytes_t)-DATA_BITS-1:0], rxByte};
				lastByte <= rxByte;
				rxCount <= rxCount + 1'b1;
			end
			if (frameError)
				errorCount <= errorCount + 1'b1; // Wraps at 255.
		end
	end

endmodule

//--- logic/uartReceiver.sv
/*
	8N1 serial receiver.
	Two-flop input synchronizer, start bit check at half a bit,
	mid-bit data sampling. Pulses rxValid on a good stop bit and
	frameError on a low one.
*/
`timescale 1ns/10ps

module uartReceiver import btLinkPkg::*; (
	input logic clock,
	input logic reset,
	input logic rxd,
	output serialByte_t rxByte,
	output logic rxValid,
	output logic frameError
);

	logic [1:0] rxSync;
	logic rxPrev; // Used for falling edge detection.
	rxState_t state;
	bitTimer_t timer;
	bitIndex_t bitIndex;
	serialByte_t shiftReg;

	wire rxLine = rxSync[1];
	wire halfBit = (timer == bitTimer_t'(BIT_CLOCKS / 2 - 1));
	wire bitDone = (timer == bitTimer_t'(BIT_CLOCKS - 1));
	wire sampleData = (state == DATA) && bitDone;
	wire stopGood = (state == STOP) && bitDone && rxLine;

	always_ff @(posedge clock) begin
		if (reset) begin
			rxSync <= 2'b11;
			rxPrev <= 1'b1;
			state <= IDLE;
			timer <= '0;
			bitIndex <= '0;
			rxValid <= 1'b0;
			frameError <= 1'b0;
		end else begin
			rxSync <= {rxSync[0], rxd};
			rxPrev <= rxLine;
			rxValid <= 1'b0;
			frameError <= 1'b0;
			timer <= timer + 1'b1;
			case (state)
				IDLE: begin
					timer <= '0;
					// A low line after a bad frame must go high first.
					if (rxPrev && !rxLine)
						state <= START;
				end
				START: begin
					if (halfBit) begin
						timer <= '0;
						bitIndex <= '0;
						state <= rxLine ? IDLE : DATA; // Glitch check.
					end
				end
				DATA: begin
					if (bitDone) begin
						bitIndex <= bitIndex + 1'b1;
						if (bitIndex == bitIndex_t'(DATA_BITS - 1))
							state <= STOP;
					end
				end
				STOP: begin
					if (bitDone) begin
						rxValid <= rxLine;
						frameError <= !rxLine; // Byte is dropped.
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// The LSB arrives first.
	always_ff @(posedge clock) begin
		if (sampleData)
			shiftReg <= {rxLine, shiftReg[DATA_BITS-1:1]};
		if (stopGood)
			rxByte <= shiftReg;
	end

endmodule

//--- logic/uartTransmitter.sv
/*
	8N1 serial transmitter.
	Latches a byte on a start pulse, sends start bit, eight data
	bits LSB first and a stop bit, and holds busy for the frame.
*/
`timescale 1ns/10ps

module uartTransmitter import btLinkPkg::*; (
	input logic clock,
	input logic reset,
	input logic start,
	input serialByte_t txData,
	output logic txd,
	output logic busy
);

	txState_t state;
	bitTimer_t timer;
	bitIndex_t bitIndex;
	serialByte_t shiftReg;

	wire bitDone = (timer == bitTimer_t'(BIT_CLOCKS - 1));

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= TX_IDLE;
			timer <= '0;
			bitIndex <= '0;
			shiftReg <= '0;
			txd <= 1'b1; // Line idles high.
		end else begin
			timer <= (state == TX_IDLE || bitDone) ? '0 : timer + 1'b1;
			case (state)
				TX_IDLE: begin
					if (start) begin // Pulses while busy never reach here.
						shiftReg <= txData;
						txd <= 1'b0;
						state <= TX_START;
					end
				end
				TX_START: begin
					if (bitDone) begin
						txd <= shiftReg[0];
						bitIndex <= '0;
						state <= TX_DATA;
					end
				end
				TX_DATA: begin
					if (bitDone) begin
						if (bitIndex == bitIndex_t'(DATA_BITS - 1)) begin
							txd <= 1'b1; // Stop bit.
							state <= TX_STOP;
						end else begin
							txd <= shiftReg[1];
							shiftReg <= shiftReg >> 1;
							bitIndex <= bitIndex + 1'b1;
						end
					end
				end
				TX_STOP: begin
					if (bitDone)
						state <= TX_IDLE;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	assign busy = (state != TX_IDLE);

endmodule
